// ==== bench/traffic_ctrl_tb.sv ====
`timescale 1ns/100ps
`include "traffic_ctrl_settings.svh"

module traffic_ctrl_tb;

   import traffic_ctrl_pkg::*;

   localparam int MAX_TESTS   = 16;
   localparam int WDOG_MARGIN = 3000;  // CSR traffic around the runs

   logic                    clk;
   logic                    rst_n;
   logic [`AVMM_ADDR_W-1:0] avmm_addr;
   logic                    avmm_read;
   logic                    avmm_write;
   logic [`AVMM_DATA_W-1:0] avmm_wdata;
   logic [`AVMM_DATA_W-1:0] avmm_rdata;
   logic                    avmm_wait;
   logic [3:0]              port_sel;

   // Test table with one row per run
   string       t_name [MAX_TESTS];
   int          t_lane [MAX_TESTS];
   int          t_pkts [MAX_TESTS];
   int          t_len  [MAX_TESTS];   // Bytes per packet
   bit          t_inj  [MAX_TESTS];
   logic [31:0] t_seed [MAX_TESTS];
   int          n_tests;
   bit          table_ready;

   // Counter model per lane that accumulates until a clear
   cnt_t exp_good  [`NUM_ETH];
   cnt_t exp_bad   [`NUM_ETH];
   cnt_t exp_bytes [`NUM_ETH];

   int     err_cnt;
   int     chk_cnt;
   int     cyc;        // Free-running cycle count
   integer seed_var;

   multi_port_traffic_ctrl u_dut (
      .clk                (clk),
      .i_rst_n            (rst_n),
      .i_avmm_addr        (avmm_addr),
      .i_avmm_read        (avmm_read),
      .i_avmm_write       (avmm_write),
      .i_avmm_writedata   (avmm_wdata),
      .o_avmm_readdata    (avmm_rdata),
      .o_avmm_waitrequest (avmm_wait),
      .i_csr_port_sel     (port_sel)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   always @(posedge clk) cyc <= cyc + 1;

   // ------------------------------------------------------------------------
   // CSR access
   // ------------------------------------------------------------------------
   task automatic csr_write(input int lane, input logic [15:0] addr, input logic [31:0] data);
      @(posedge clk);
      port_sel   <= 4'(lane);
      avmm_addr  <= addr;
      avmm_wdata <= data;
      avmm_write <= 1'b1;
      @(posedge clk);
      avmm_write <= 1'b0;     // Zero wait state so one cycle
   endtask

   task automatic csr_read(input int lane, input logic [15:0] addr, output cnt_t data);
      int waits;
      waits = 0;
      @(posedge clk);
      port_sel  <= 4'(lane);
      avmm_addr <= addr;
      avmm_read <= 1'b1;
      @(negedge clk);
      while (avmm_wait && waits < 8) begin   // Hold read until wait drops
         waits++;
         @(negedge clk);
      end
      if (avmm_wait) begin
         err_cnt++;
         $display("Read of address %0d on lane %0d never completed, waitrequest stuck high",
                  addr, lane);
      end
      data = avmm_rdata;   // Stable mid-cycle
      @(posedge clk);
      avmm_read <= 1'b0;
   endtask

   // ------------------------------------------------------------------------
   // Compares
   // ------------------------------------------------------------------------
   task automatic check_cnt(input string label, input cnt_t exp, input cnt_t act);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("ERROR %s: expected %0d, actual %0d", label, exp, act);
      end
   endtask

   task automatic check_cfg(input string label, input cfg_word_u exp, input cfg_word_u act);
      chk_cnt++;
      if (act.raw !== exp.raw) begin
         err_cnt++;
         $display("ERROR %s: expected 0x%08h, actual 0x%08h", label, exp.raw, act.raw);
      end
   endtask

   // Check all lanes against the model to catch crosstalk
   task automatic check_lanes(input string label);
      cnt_t rd;
      for (int l = 0; l < `NUM_ETH; l++) begin
         csr_read(l, `CSR_ADDR_GOOD, rd);
         check_cnt($sformatf("%s lane %0d good", label, l), exp_good[l], rd);
         csr_read(l, `CSR_ADDR_BAD, rd);
         check_cnt($sformatf("%s lane %0d bad", label, l), exp_bad[l], rd);
         csr_read(l, `CSR_ADDR_BYTES, rd);
         check_cnt($sformatf("%s lane %0d bytes", label, l), exp_bytes[l], rd);
      end
   endtask

   // Poll STATUS until done within a budget from the run length
   task automatic wait_done(input int idx);
      int   budget;
      int   t0;
      cnt_t st;
      budget = (((t_len[idx] + 7) / 8) + 1) * t_pkts[idx] + 64;
      t0     = cyc;
      csr_read(t_lane[idx], `CSR_ADDR_STATUS, st);
      check_cnt({t_name[idx], " busy"}, 32'h1, st);   // Run under way
      while (!st[1] && (cyc - t0) < budget)
         csr_read(t_lane[idx], `CSR_ADDR_STATUS, st);
      if (!st[1]) begin
         err_cnt++;
         $display("Test %s: lane %0d did not report done within %0d cycles",
                  t_name[idx], t_lane[idx], budget);
      end
   endtask

   task automatic add_test(input string name, input int lane, input int pkts, input int len,
                           input bit inj);
      t_name[n_tests] = name;
      t_lane[n_tests] = lane;
      t_pkts[n_tests] = pkts;
      t_len[n_tests]  = len;
      t_inj[n_tests]  = inj;
      t_seed[n_tests] = $random(seed_var);
      n_tests++;
   endtask

   task automatic run_test(input int idx);
      cfg_word_u cfg;
      cfg_word_u exp_cfg;
      cfg_word_u act_cfg;
      cnt_t      rd;
      int        lane;
      lane = t_lane[idx];
      csr_write(lane, `CSR_ADDR_SEED, t_seed[idx]);
      cfg.raw          = '0;
      cfg.f.start      = 1'b1;
      cfg.f.inject_err = t_inj[idx];
      cfg.f.pkt_len    = 12'(t_len[idx]);
      cfg.f.num_pkts   = 16'(t_pkts[idx]);
      csr_write(lane, `CSR_ADDR_CFG, cfg.raw);
      wait_done(idx);
      exp_cfg         = cfg;
      exp_cfg.f.start = 1'b0;   // Command bit self-clears
      csr_read(lane, `CSR_ADDR_CFG, rd);
      act_cfg.raw = rd;
      check_cfg({t_name[idx], " cfg"}, exp_cfg, act_cfg);
      csr_read(lane, `CSR_ADDR_STATUS, rd);
      check_cnt({t_name[idx], " status"}, 32'h2, rd);   // Done and not busy
      if (t_inj[idx])
         exp_bad[lane] += cnt_t'(t_pkts[idx]);
      else
         exp_good[lane] += cnt_t'(t_pkts[idx]);
      exp_bytes[lane] += cnt_t'(t_pkts[idx] * t_len[idx]);
      check_lanes(t_name[idx]);
   endtask

   task automatic clear_lane(input int lane);
      cfg_word_u cfg;
      cfg_word_u exp_cfg;
      cfg_word_u act_cfg;
      cnt_t      rd;
      cfg.raw        = '0;
      cfg.f.clear    = 1'b1;
      cfg.f.pkt_len  = 12'd64;   // Fields kept, no start
      cfg.f.num_pkts = 16'(lane + 1);
      csr_write(lane, `CSR_ADDR_CFG, cfg.raw);
      exp_good[lane]  = '0;
      exp_bad[lane]   = '0;
      exp_bytes[lane] = '0;
      exp_cfg         = cfg;
      exp_cfg.f.clear = 1'b0;    // Command bit self-clears
      csr_read(lane, `CSR_ADDR_CFG, rd);
      act_cfg.raw = rd;
      check_cfg($sformatf("clear lane %0d cfg", lane), exp_cfg, act_cfg);
      csr_read(lane, `CSR_ADDR_STATUS, rd);
      check_cnt($sformatf("clear lane %0d status", lane), 32'h0, rd);
      check_lanes($sformatf("clear lane %0d", lane));
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial begin
      cfg_word_u zero_cfg;
      cfg_word_u act_cfg;
      cnt_t      rd;
      seed_var    = 68564;
      err_cnt     = 0;
      chk_cnt     = 0;
      cyc         = 0;
      n_tests     = 0;
      table_ready = 1'b0;
      rst_n       = 1'b0;
      avmm_addr   = '0;
      avmm_read   = 1'b0;
      avmm_write  = 1'b0;
      avmm_wdata  = '0;
      port_sel    = '0;
      zero_cfg.raw = '0;
      for (int l = 0; l < `NUM_ETH; l++) begin
         exp_good[l]  = '0;
         exp_bad[l]   = '0;
         exp_bytes[l] = '0;
      end

      // name, lane, packets, bytes, inject
      add_test("len1_lane0",       0, 6, 1,    1'b0);
      add_test("len8_lane1",       1, 5, 8,    1'b0);
      add_test("len9_lane2",       2, 4, 9,    1'b0);
      add_test("len1500_lane3",    3, 3, 1500, 1'b0);
      add_test("inject_lane1",     1, 4, 64,   1'b1);
      add_test("len60_lane0",      0, 7, 60,   1'b0);
      add_test("inject1500_lane2", 2, 2, 1500, 1'b1);
      table_ready = 1'b1;

      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      // Reset state of every lane
      for (int l = 0; l < `NUM_ETH; l++) begin
         csr_read(l, `CSR_ADDR_CFG, rd);
         act_cfg.raw = rd;
         check_cfg($sformatf("reset lane %0d cfg", l), zero_cfg, act_cfg);
         csr_read(l, `CSR_ADDR_STATUS, rd);
         check_cnt($sformatf("reset lane %0d status", l), 32'h0, rd);
      end
      check_lanes("reset");

      for (int i = 0; i < n_tests; i++)
         run_test(i);
      for (int l = 0; l < `NUM_ETH; l++)
         clear_lane(l);

      $display("%0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   // Watchdog sized from the table
   initial begin
      int limit;
      wait (table_ready);
      limit = WDOG_MARGIN;
      for (int i = 0; i < n_tests; i++)
         limit += (((t_len[i] + 7) / 8) + 1) * t_pkts[i];
      repeat (limit) @(posedge clk);
      $display("Timeout: simulation still running after %0d cycles, stopping", limit);
      $display("Some tests failed");
      $finish;
   end

endmodule

// ==== hdl/multi_port_traffic_ctrl.sv ====
`timescale 1ns/100ps
`include "traffic_ctrl_settings.svh"

module multi_port_traffic_ctrl (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic [`AVMM_ADDR_W-1:0]    i_avmm_addr,        // CSR address
   input  logic                       i_avmm_read,
   input  logic                       i_avmm_write,
   input  logic [`AVMM_DATA_W-1:0]    i_avmm_writedata,
   output logic [`AVMM_DATA_W-1:0]    o_avmm_readdata,
   output logic                       o_avmm_waitrequest, // High in first read cycle
   input  logic [3:0]                 i_csr_port_sel      // Lane for this access
);

   import traffic_ctrl_pkg::*;

   cfg_word_u                cfg      [`NUM_ETH];
   logic [`AVMM_DATA_W-1:0]  seed     [`NUM_ETH];
   logic                     start    [`NUM_ETH];
   logic                     clear    [`NUM_ETH];
   logic                     busy     [`NUM_ETH];
   logic                     done     [`NUM_ETH];
   cnt_t                     good_cnt [`NUM_ETH];
   cnt_t                     bad_cnt  [`NUM_ETH];
   cnt_t                     byte_cnt [`NUM_ETH];

   traffic_csr u_csr (
      .clk,
      .i_rst_n,
      .i_avmm_addr,
      .i_avmm_read,
      .i_avmm_write,
      .i_avmm_writedata,
      .i_csr_port_sel,
      .o_avmm_readdata,
      .o_avmm_waitrequest,
      .o_cfg      (cfg),
      .o_seed     (seed),
      .o_start    (start),
      .o_clear    (clear),
      .i_busy     (busy),
      .i_done     (done),
      .i_good_cnt (good_cnt),
      .i_bad_cnt  (bad_cnt),
      .i_byte_cnt (byte_cnt)
   );

   // ------------------------------------------------------------------------
   // Lanes, TX stream looped into RX with no MAC in between
   // ------------------------------------------------------------------------
   for (genvar i = 0; i < `NUM_ETH; i++) begin : g_lane
      logic      lb_valid;   // Loopback beat
      logic      lb_sop;
      logic      lb_eop;
      st_data_t  lb_data;
      st_empty_t lb_empty;

      packet_gen u_gen (
         .clk,
         .i_rst_n,
         .i_cfg   (cfg[i]),
         .i_seed  (seed[i]),
         .i_start (start[i]),
         .o_valid (lb_valid),
         .o_sop   (lb_sop),
         .o_eop   (lb_eop),
         .o_data  (lb_data),
         .o_empty (lb_empty),
         .o_busy  (busy[i]),
         .o_done  (done[i])
      );

      packet_mon u_mon (
         .clk,
         .i_rst_n,
         .i_seed     (seed[i]),   // Same seed, same expected sequence
         .i_start    (start[i]),
         .i_clear    (clear[i]),
         .i_valid    (lb_valid),
         .i_sop      (lb_sop),
         .i_eop      (lb_eop),
         .i_data     (lb_data),
         .i_empty    (lb_empty),
         .o_good_cnt (good_cnt[i]),
         .o_bad_cnt  (bad_cnt[i]),
         .o_byte_cnt (byte_cnt[i])
      );
   end

endmodule

// ==== hdl/packet_gen.sv ====
`timescale 1ns/100ps
`include "traffic_ctrl_settings.svh"

module packet_gen (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  traffic_ctrl_pkg::cfg_word_u   i_cfg,     // Read through field view
   input  logic [31:0]                   i_seed,
   input  logic                          i_start,   // Ignored unless idle
   output logic                          o_valid,
   output logic                          o_sop,
   output logic                          o_eop,
   output traffic_ctrl_pkg::st_data_t    o_data,
   output traffic_ctrl_pkg::st_empty_t   o_empty,
   output logic                          o_busy,
   output logic                          o_done
);

   import traffic_ctrl_pkg::*;

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_RUN  = 2'd1;  // A beat is on the bus
   localparam logic [1:0] S_GAP  = 2'd2;  // Idle cycle between packets

   logic [1:0]  state_q;
   logic [11:0] rem_q;      // Bytes still to send after current beat
   logic [15:0] pkts_q;     // Packets left, current one included
   logic [11:0] len_q;      // Latched at start
   logic        inj_q;
   st_data_t    lfsr_q;     // Payload of the next beat

   logic        emit;       // Put a beat out next cycle
   logic        emit_sop;
   logic        emit_last;
   logic [11:0] emit_rem;   // Bytes left before this beat
   logic        emit_inj;
   st_data_t    emit_lfsr;

   // ------------------------------------------------------------------------
   // Next beat select
   // ------------------------------------------------------------------------
   always_comb begin
      emit      = 1'b0;
      emit_sop  = 1'b0;
      emit_rem  = rem_q;
      emit_lfsr = lfsr_q;
      emit_inj  = inj_q;
      case (state_q)
         S_IDLE: begin
            if (i_start && i_cfg.f.num_pkts != '0) begin
               emit      = 1'b1;
               emit_sop  = 1'b1;
               emit_rem  = i_cfg.f.pkt_len;
               emit_lfsr = lfsr_seed(i_seed);   // Fresh sequence per run
               emit_inj  = i_cfg.f.inject_err;
            end
         end
         S_RUN: emit = (rem_q != '0);   // Zero means eop just went out
         S_GAP: begin
            emit     = 1'b1;
            emit_sop = 1'b1;
            emit_rem = len_q;
         end
         default: emit = 1'b0;
      endcase
   end

   assign emit_last = (emit_rem <= 12'd8);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= S_IDLE;
         o_valid <= 1'b0;
         o_sop   <= 1'b0;
         o_eop   <= 1'b0;
         o_busy  <= 1'b0;
         o_done  <= 1'b0;
         rem_q   <= '0;
         pkts_q  <= '0;
      end else begin
         o_valid <= emit;
         o_sop   <= emit_sop;
         o_eop   <= emit & emit_last;
         if (emit)
            rem_q <= emit_last ? 12'd0 : emit_rem - 12'd8;
         case (state_q)
            S_IDLE: begin
               if (i_start) begin
                  o_done <= (i_cfg.f.num_pkts == '0);  // Empty run ends at once
                  if (i_cfg.f.num_pkts != '0) begin
                     state_q <= S_RUN;
                     o_busy  <= 1'b1;
                     pkts_q  <= i_cfg.f.num_pkts;
                  end
               end
            end
            S_RUN: begin
               if (rem_q == '0) begin
                  if (pkts_q == 16'd1) begin
                     state_q <= S_IDLE;   // Run over
                     o_busy  <= 1'b0;
                     o_done  <= 1'b1;
                  end else begin
                     state_q <= S_GAP;
                     pkts_q  <= pkts_q - 16'd1;
                  end
               end
            end
            default: state_q <= S_RUN;   // Gap lasts one cycle
         endcase
      end
   end

   // Payload path
   always_ff @(posedge clk) begin
      if (state_q == S_IDLE && i_start) begin
         len_q <= i_cfg.f.pkt_len;
         inj_q <= i_cfg.f.inject_err;
      end
      if (emit) begin
         o_data  <= emit_lfsr ^ {{(`ST_DATA_W-1){1'b0}}, emit_inj & emit_sop};
         o_empty <= emit_last ? st_empty_t'(4'd8 - emit_rem[3:0]) : '0;
         lfsr_q  <= lfsr_next(emit_lfsr);
      end
   end

   a_ctl_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_sop || o_eop) |-> o_valid);

   a_len_nonzero: assert property (@(posedge clk) disable iff (!i_rst_n)
      (state_q == S_IDLE && i_start && i_cfg.f.num_pkts != '0) |-> (i_cfg.f.pkt_len != '0));

endmodule

// ==== hdl/packet_mon.sv ====
`timescale 1ns/100ps
`include "traffic_ctrl_settings.svh"

module packet_mon (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic [31:0]                   i_seed,
   input  logic                          i_start,    // Reload expected sequence
   input  logic                          i_clear,    // Zero all counters
   input  logic                          i_valid,    // Every beat accepted
   input  logic                          i_sop,
   input  logic                          i_eop,
   input  traffic_ctrl_pkg::st_data_t    i_data,
   input  traffic_ctrl_pkg::st_empty_t   i_empty,
   output traffic_ctrl_pkg::cnt_t        o_good_cnt,
   output traffic_ctrl_pkg::cnt_t        o_bad_cnt,
   output traffic_ctrl_pkg::cnt_t        o_byte_cnt
);

   import traffic_ctrl_pkg::*;

   st_data_t    lfsr_q;       // Expected data of next beat
   logic        err_q;        // Mismatch seen so far in packet
   logic [12:0] pkt_bytes_q;  // Bytes of earlier beats in packet
   logic        in_pkt_q;     // Between sop and eop

   logic        pkt_err;
   logic [3:0]  beat_bytes;
   logic [12:0] pkt_sum;

   // ------------------------------------------------------------------------
   // Per-beat check
   // ------------------------------------------------------------------------
   always_comb begin
      pkt_err    = (i_sop ? 1'b0 : err_q) | (i_data != lfsr_q);
      beat_bytes = i_eop ? 4'd8 - {1'b0, i_empty} : 4'd8;
      pkt_sum    = (i_sop ? 13'd0 : pkt_bytes_q) + 13'(beat_bytes);
   end

   always_ff @(posedge clk) begin
      if (i_start)
         lfsr_q <= lfsr_seed(i_seed);  // Same expansion as the generator
      else if (i_valid)
         lfsr_q <= lfsr_next(lfsr_q);
      if (i_valid) begin
         err_q       <= pkt_err;
         pkt_bytes_q <= pkt_sum;
      end
   end

   // ------------------------------------------------------------------------
   // Counters, updated after eop
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_good_cnt <= '0;
         o_bad_cnt  <= '0;
         o_byte_cnt <= '0;
         in_pkt_q   <= 1'b0;
      end else begin
         if (i_clear) begin
            o_good_cnt <= '0;
            o_bad_cnt  <= '0;
            o_byte_cnt <= '0;
         end else if (i_valid && i_eop) begin
            if (pkt_err)
               o_bad_cnt <= o_bad_cnt + 1'b1;
            else
               o_good_cnt <= o_good_cnt + 1'b1;
            o_byte_cnt <= o_byte_cnt + cnt_t'(pkt_sum);
         end
         if (i_valid)
            in_pkt_q <= ~i_eop;
      end
   end

   // Packets never nest on the loopback
   a_no_double_sop: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_valid && i_sop) |-> !in_pkt_q);

endmodule

// ==== hdl/traffic_csr.sv ====
`timescale 1ns/100ps
`include "traffic_ctrl_settings.svh"

module traffic_csr (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic [`AVMM_ADDR_W-1:0]       i_avmm_addr,        // Register address
   input  logic                          i_avmm_read,        // Held until waitrequest drops
   input  logic                          i_avmm_write,       // Zero wait state
   input  logic [`AVMM_DATA_W-1:0]       i_avmm_writedata,
   input  logic [3:0]                    i_csr_port_sel,     // Lane select
   output logic [`AVMM_DATA_W-1:0]       o_avmm_readdata,
   output logic                          o_avmm_waitrequest,
   output traffic_ctrl_pkg::cfg_word_u   o_cfg [`NUM_ETH],   // Stored config per lane
   output logic [`AVMM_DATA_W-1:0]       o_seed [`NUM_ETH],
   output logic                          o_start [`NUM_ETH], // 1-cycle pulse
   output logic                          o_clear [`NUM_ETH], // 1-cycle pulse
   input  logic                          i_busy [`NUM_ETH],
   input  logic                          i_done [`NUM_ETH],
   input  traffic_ctrl_pkg::cnt_t        i_good_cnt [`NUM_ETH],
   input  traffic_ctrl_pkg::cnt_t        i_bad_cnt [`NUM_ETH],
   input  traffic_ctrl_pkg::cnt_t        i_byte_cnt [`NUM_ETH]
);

   import traffic_ctrl_pkg::*;

   cfg_word_u wr_cfg;               // Incoming word, decoded
   cfg_word_u wr_store;             // What gets kept
   logic      done_hide [`NUM_ETH]; // Masks done after a clear
   logic      rd_pend;              // Second cycle of a read
   cnt_t      rd_mux;

   // ------------------------------------------------------------------------
   // Write decode
   // ------------------------------------------------------------------------
   always_comb begin
      wr_cfg.raw       = i_avmm_writedata;
      wr_store         = wr_cfg;
      wr_store.f.start = 1'b0;   // Command bits never stick
      wr_store.f.clear = 1'b0;
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         for (int i = 0; i < `NUM_ETH; i++) begin
            o_cfg[i]     <= '0;
            o_start[i]   <= 1'b0;
            o_clear[i]   <= 1'b0;
            done_hide[i] <= 1'b0;
         end
      end else begin
         for (int i = 0; i < `NUM_ETH; i++) begin
            o_start[i] <= 1'b0;  // Default, pulses only
            o_clear[i] <= 1'b0;
            if (i_avmm_write && i_csr_port_sel == 4'(i) &&
                i_avmm_addr == `CSR_ADDR_CFG) begin
               o_cfg[i]   <= wr_store;
               o_start[i] <= wr_cfg.f.start;
               o_clear[i] <= wr_cfg.f.clear;
               if (wr_cfg.f.clear)
                  done_hide[i] <= 1'b1;   // Status done reads low from next cycle
               else if (wr_cfg.f.start)
                  done_hide[i] <= 1'b0;   // New run, show done again
            end
         end
      end
   end

   // Seeds, payload only
   always_ff @(posedge clk) begin
      for (int i = 0; i < `NUM_ETH; i++) begin
         if (i_avmm_write && i_csr_port_sel == 4'(i) && i_avmm_addr == `CSR_ADDR_SEED)
            o_seed[i] <= i_avmm_writedata;
      end
   end

   // ------------------------------------------------------------------------
   // Read path, one wait state
   // ------------------------------------------------------------------------
   always_comb begin
      rd_mux = '0;
      for (int i = 0; i < `NUM_ETH; i++) begin
         if (i_csr_port_sel == 4'(i)) begin
            case (i_avmm_addr)
               `CSR_ADDR_CFG:    rd_mux = o_cfg[i].raw;
               `CSR_ADDR_STATUS: rd_mux = {30'd0, i_done[i] & ~done_hide[i], i_busy[i]};
               `CSR_ADDR_GOOD:   rd_mux = i_good_cnt[i];
               `CSR_ADDR_BAD:    rd_mux = i_bad_cnt[i];
               `CSR_ADDR_BYTES:  rd_mux = i_byte_cnt[i];
               `CSR_ADDR_SEED:   rd_mux = o_seed[i];
               default:          rd_mux = '0;  // Unmapped reads as zero
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n)
         rd_pend <= 1'b0;
      else
         rd_pend <= i_avmm_read & ~rd_pend;  // Drops after the data cycle
   end

   always_ff @(posedge clk) begin
      if (i_avmm_read && !rd_pend)
         o_avmm_readdata <= rd_mux;  // Captured in the wait cycle
   end

   assign o_avmm_waitrequest = i_avmm_read & ~rd_pend;

   // Master never overlaps commands
   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_avmm_read && i_avmm_write));

   // Lane select stays inside the built lanes
   a_sel_range: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_avmm_read || i_avmm_write) |-> (i_csr_port_sel < `NUM_ETH));

endmodule

// ==== hdl/traffic_ctrl_pkg.sv ====
`include "traffic_ctrl_settings.svh"

package traffic_ctrl_pkg;

   // Field view of the per-lane config word
   typedef struct packed {
      logic        start;       // [31] Kick off a run
      logic        clear;       // [30] Zero counters and done
      logic        inject_err;  // [29] Corrupt first beat of every packet
      logic        rsvd;        // [28]
      logic [11:0] pkt_len;     // [27:16] Bytes per packet
      logic [15:0] num_pkts;    // [15:0] Packets per run
   } cfg_fields_t;

   // Same 32 bits, raw for the bus, fields for the lane
   typedef union packed {
      logic [`AVMM_DATA_W-1:0] raw;
      cfg_fields_t             f;
   } cfg_word_u;

   typedef logic [`ST_DATA_W-1:0]  st_data_t;   // One stream beat
   typedef logic [`ST_EMPTY_W-1:0] st_empty_t;  // Unused bytes, last beat
   typedef logic [31:0]            cnt_t;       // Counters and read data

   // Galois taps for x^64 + x^63 + x^61 + x^60 + 1
   localparam st_data_t LFSR_POLY = 64'hD800_0000_0000_0000;

   // Seed expansion, never all zero
   function automatic st_data_t lfsr_seed(input logic [31:0] seed);
      return {~seed, seed};
   endfunction

   function automatic st_data_t lfsr_next(input st_data_t s);
      return {1'b0, s[`ST_DATA_W-1:1]} ^ (s[0] ? LFSR_POLY : '0);
   endfunction

endpackage

// ==== hdl/traffic_ctrl_settings.svh ====
`ifndef TRAFFIC_CTRL_SETTINGS_SVH
`define TRAFFIC_CTRL_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Lane count and bus widths
// ---------------------------------------------------------------------------
`define NUM_ETH      4    // Ethernet lanes
`define AVMM_DATA_W  32   // CSR data
`define AVMM_ADDR_W  16   // CSR address
`define ST_DATA_W    64   // Stream beat, 8 bytes
`define ST_EMPTY_W   3    // Unused bytes in last beat

// ---------------------------------------------------------------------------
// CSR register map, per lane
// ---------------------------------------------------------------------------
`define CSR_ADDR_CFG     16'h0000  // Config word, start/clear self-clearing
`define CSR_ADDR_STATUS  16'h0001  // {done, busy}
`define CSR_ADDR_GOOD    16'h0002  // Good packet count
`define CSR_ADDR_BAD     16'h0003  // Bad packet count
`define CSR_ADDR_BYTES   16'h0004  // Received byte count
`define CSR_ADDR_SEED    16'h0005  // Payload LFSR seed

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the traffic controller testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtraffic_ctrl_tb

verilator --binary --timing --assert -Wno-fatal \
   --top-module traffic_ctrl_tb -f traffic_ctrl.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "All tests passed" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

// ==== traffic_ctrl.f ====
+incdir+hdl
hdl/traffic_ctrl_pkg.sv
hdl/traffic_csr.sv
hdl/packet_gen.sv
hdl/packet_mon.sv
hdl/multi_port_traffic_ctrl.sv
bench/traffic_ctrl_tb.sv
